/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = fpu_cluster_tb
FILELIST  = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

/* flist.f */
fpu_format_pkg.sv
fpu_flow_pkg.sv
operand_fwd.sv
result_queue.sv
fp_add_unit.sv
fp_mul_unit.sv
result_bus_arbiter.sv
fpu_cluster.sv
fpu_cluster_asserts.sv
fpu_cluster_tb.sv

/* fp_add_unit.sv */
module fp_add_unit import fpu_format_pkg::*, fpu_flow_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  add_op_e           op,
  input  logic [tag_w-1:0]  tag,
  input  logic [fp_w-1:0]   a,
  input  logic [fp_w-1:0]   b,
  input  logic              q_pop,
  output logic              q_valid,
  output logic [tag_w-1:0]  q_tag,
  output logic [fp_w-1:0]   q_data,
  output logic [flag_w-1:0] q_flags
);

  // ####################
  // Stage 1

  logic [fp_w-1:0]      x, y, logic_res;
  logic                 x_s, y_s, is_sub, is_logic, x_big, nan_in;
  logic [exp_w-1:0]     x_e, y_e, diff, sh_amt;
  logic [man_w:0]       x_m, y_m;
  logic [2*man_w+7:0]   shift_wide;
  logic [man_w+3:0]     small_al;

  always_comb begin
    // Reverse subtract is b - a
    x        = (op == add_op_rsub) ? b : a;
    y        = (op == add_op_rsub) ? a : b;
    is_sub   = (op == add_op_sub) || (op == add_op_rsub);
    is_logic = op inside {add_op_and, add_op_or, add_op_xor, add_op_andn};
    x_s      = x[fp_w-1];
    y_s      = y[fp_w-1] ^ is_sub;
    x_e      = x[fp_w-2:man_w];
    y_e      = y[fp_w-2:man_w];
    // Subnormals flush to zero
    x_m      = (x_e == '0) ? '0 : {1'b1, x[man_w-1:0]};
    y_m      = (y_e == '0) ? '0 : {1'b1, y[man_w-1:0]};
    nan_in   = !is_logic && ((x_e == '1) || (y_e == '1));
    x_big    = {x_e, x_m} >= {y_e, y_m};
    diff     = x_big ? x_e - y_e : y_e - x_e;
    sh_amt   = (diff > 5'd15) ? 5'd15 : diff;
    // Guard, round and sticky below the smaller significand
    shift_wide = {(x_big ? y_m : x_m), 3'b000, {(man_w+4){1'b0}}} >> sh_amt;
    small_al   = {shift_wide[2*man_w+7:man_w+5],
                  shift_wide[man_w+4] | (|shift_wide[man_w+3:0])};
    case (op)
      add_op_and:  logic_res = a & b;
      add_op_or:   logic_res = a | b;
      add_op_xor:  logic_res = a ^ b;
      add_op_andn: logic_res = a & ~b;
      default:     logic_res = '0;
    endcase
  end

  logic                 s1_valid, s1_logic, s1_nan, s1_eff_sub, s1_sign, s1_zero_sign;
  logic [tag_w-1:0]     s1_tag;
  logic [fp_w-1:0]      s1_logic_res;
  logic [exp_w-1:0]     s1_exp;
  logic [man_w+3:0]     s1_big_m, s1_small_m;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_tag       <= tag;
    s1_logic     <= is_logic;
    s1_logic_res <= logic_res;
    s1_nan       <= nan_in;
    s1_eff_sub   <= x_s ^ y_s;
    s1_sign      <= x_big ? x_s : y_s;
    s1_zero_sign <= x_s & y_s;
    s1_exp       <= x_big ? x_e : y_e;
    s1_big_m     <= {(x_big ? x_m : y_m), 3'b000};
    s1_small_m   <= small_al;
  end

  // ####################
  // Stage 2

  logic [man_w+4:0]     sum, norm;
  logic [3:0]           lzc;
  logic signed [6:0]    exp_n;
  logic                 lost;
  logic [fp_w-1:0]      r_data;
  logic [flag_w-1:0]    r_flags;

  always_comb begin
    sum = s1_eff_sub ? {1'b0, s1_big_m} - {1'b0, s1_small_m}
                     : {1'b0, s1_big_m} + {1'b0, s1_small_m};
    lzc = '0;
    for (int i = 0; i <= man_w + 4; i++) begin
      if (sum[i]) begin
        lzc = 4'(man_w + 4 - i);
      end
    end
    norm  = sum << lzc;
    exp_n = $signed({2'b00, s1_exp}) + 7'sd1 - $signed({3'b000, lzc});
    lost  = |norm[3:0];
    r_flags = '0;
    if (s1_logic) begin
      r_data = s1_logic_res;
    end else if (s1_nan) begin
      r_data            = qnan_val;
      r_flags[flag_inv] = 1'b1;
    end else if (sum == '0) begin
      r_data = {s1_zero_sign, {(fp_w-1){1'b0}}};
    end else if (exp_n >= 7'sd31) begin
      r_data            = {s1_sign, {exp_w{1'b1}}, {man_w{1'b0}}};
      r_flags[flag_ovf] = 1'b1;
      r_flags[flag_inx] = 1'b1;
    end else if (exp_n <= 7'sd0) begin
      r_data            = {s1_sign, {(fp_w-1){1'b0}}};
      r_flags[flag_unf] = 1'b1;
      r_flags[flag_inx] = 1'b1;
    end else begin
      r_data            = {s1_sign, exp_n[exp_w-1:0], norm[man_w+3:4]};
      r_flags[flag_inx] = lost;
    end
  end

  result_queue u_queue (
    .clk        (clk),
    .rst        (rst),
    .push       (s1_valid),
    .push_tag   (s1_tag),
    .push_data  (r_data),
    .push_flags (r_flags),
    .pop        (q_pop),
    .valid      (q_valid),
    .head_tag   (q_tag),
    .head_data  (q_data),
    .head_flags (q_flags)
  );

endmodule

/* fp_mul_unit.sv */
module fp_mul_unit import fpu_format_pkg::*, fpu_flow_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  mul_op_e           op,
  input  logic [tag_w-1:0]  tag,
  input  logic [fp_w-1:0]   a,
  input  logic [fp_w-1:0]   b,
  input  logic              q_pop,
  output logic              q_valid,
  output logic [tag_w-1:0]  q_tag,
  output logic [fp_w-1:0]   q_data,
  output logic [flag_w-1:0] q_flags
);

  // ####################
  // Stage 1

  logic [fp_w-1:0]  fb;
  logic [exp_w-1:0] ea, eb;

  always_comb begin
    // Square uses a for both factors
    fb = (op == mul_op_sqr) ? a : b;
    ea = a[fp_w-2:man_w];
    eb = fb[fp_w-2:man_w];
  end

  logic                   s1_valid, s1_nan, s1_zero, s1_sign;
  logic [tag_w-1:0]       s1_tag;
  logic [2*man_w+1:0]     s1_prod;
  logic signed [6:0]      s1_exp;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_tag  <= tag;
    s1_nan  <= (ea == '1) || (eb == '1);
    s1_zero <= (ea == '0) || (eb == '0);
    s1_sign <= a[fp_w-1] ^ fb[fp_w-1] ^ (op == mul_op_nmul);
    s1_prod <= {1'b1, a[man_w-1:0]} * {1'b1, fb[man_w-1:0]};
    s1_exp  <= $signed({2'b00, ea}) + $signed({2'b00, eb}) - 7'(exp_bias);
  end

  // ####################
  // Stage 2

  logic [man_w-1:0]   man;
  logic               lost;
  logic signed [6:0]  exp_n;
  logic [fp_w-1:0]    r_data;
  logic [flag_w-1:0]  r_flags;

  always_comb begin
    // Product lies in [1, 4), at most one position of normalization
    if (s1_prod[2*man_w+1]) begin
      man   = s1_prod[2*man_w:man_w+1];
      lost  = |s1_prod[man_w:0];
      exp_n = s1_exp + 7'sd1;
    end else begin
      man   = s1_prod[2*man_w-1:man_w];
      lost  = |s1_prod[man_w-1:0];
      exp_n = s1_exp;
    end
    r_flags = '0;
    if (s1_nan) begin
      r_data            = qnan_val;
      r_flags[flag_inv] = 1'b1;
    end else if (s1_zero) begin
      r_data = {s1_sign, {(fp_w-1){1'b0}}};
    end else if (exp_n >= 7'sd31) begin
      r_data            = {s1_sign, {exp_w{1'b1}}, {man_w{1'b0}}};
      r_flags[flag_ovf] = 1'b1;
      r_flags[flag_inx] = 1'b1;
    end else if (exp_n <= 7'sd0) begin
      r_data            = {s1_sign, {(fp_w-1){1'b0}}};
      r_flags[flag_unf] = 1'b1;
      r_flags[flag_inx] = 1'b1;
    end else begin
      r_data            = {s1_sign, exp_n[exp_w-1:0], man};
      r_flags[flag_inx] = lost;
    end
  end

  result_queue u_queue (
    .clk        (clk),
    .rst        (rst),
    .push       (s1_valid),
    .push_tag   (s1_tag),
    .push_data  (r_data),
    .push_flags (r_flags),
    .pop        (q_pop),
    .valid      (q_valid),
    .head_tag   (q_tag),
    .head_data  (q_data),
    .head_flags (q_flags)
  );

endmodule

/* fpu_cluster.sv */
module fpu_cluster import fpu_format_pkg::*, fpu_flow_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              p1_valid,
  input  add_op_e           p1_op,
  input  logic [tag_w-1:0]  p1_tag,
  input  logic [fp_w-1:0]   p1_a,
  input  logic [fp_w-1:0]   p1_b,
  input  fwd_sel_e          p1_sel_a,
  input  fwd_sel_e          p1_sel_b,
  input  logic              p2_valid,
  input  mul_op_e           p2_op,
  input  logic [tag_w-1:0]  p2_tag,
  input  logic [fp_w-1:0]   p2_a,
  input  logic [fp_w-1:0]   p2_b,
  input  fwd_sel_e          p2_sel_a,
  input  fwd_sel_e          p2_sel_b,
  output logic              p1_credit,
  output logic              p2_credit,
  output logic              res_valid,
  output logic [src_w-1:0]  res_src,
  output logic [tag_w-1:0]  res_tag,
  output logic [fp_w-1:0]   res_data,
  output logic [flag_w-1:0] res_flags
);

  logic [fp_w-1:0]   p1_opa, p1_opb, p2_opa, p2_opb;
  logic              add_q_valid, add_q_pop, mul_q_valid, mul_q_pop;
  logic [tag_w-1:0]  add_q_tag, mul_q_tag;
  logic [fp_w-1:0]   add_q_data, mul_q_data;
  logic [flag_w-1:0] add_q_flags, mul_q_flags;

  // Operand forwarding from the shared result bus
  operand_fwd u_fwd_p1_a (.clk(clk), .rst(rst), .sel(p1_sel_a), .value(p1_a),
    .bus_valid(res_valid), .bus_data(res_data), .operand(p1_opa));
  operand_fwd u_fwd_p1_b (.clk(clk), .rst(rst), .sel(p1_sel_b), .value(p1_b),
    .bus_valid(res_valid), .bus_data(res_data), .operand(p1_opb));
  operand_fwd u_fwd_p2_a (.clk(clk), .rst(rst), .sel(p2_sel_a), .value(p2_a),
    .bus_valid(res_valid), .bus_data(res_data), .operand(p2_opa));
  operand_fwd u_fwd_p2_b (.clk(clk), .rst(rst), .sel(p2_sel_b), .value(p2_b),
    .bus_valid(res_valid), .bus_data(res_data), .operand(p2_opb));

  fp_add_unit u_add (
    .clk(clk), .rst(rst),
    .valid(p1_valid), .op(p1_op), .tag(p1_tag), .a(p1_opa), .b(p1_opb),
    .q_pop(add_q_pop), .q_valid(add_q_valid), .q_tag(add_q_tag),
    .q_data(add_q_data), .q_flags(add_q_flags)
  );

  fp_mul_unit u_mul (
    .clk(clk), .rst(rst),
    .valid(p2_valid), .op(p2_op), .tag(p2_tag), .a(p2_opa), .b(p2_opb),
    .q_pop(mul_q_pop), .q_valid(mul_q_valid), .q_tag(mul_q_tag),
    .q_data(mul_q_data), .q_flags(mul_q_flags)
  );

  result_bus_arbiter u_arb (
    .clk        (clk),
    .rst        (rst),
    .add_valid  (add_q_valid),
    .add_tag    (add_q_tag),
    .add_data   (add_q_data),
    .add_flags  (add_q_flags),
    .mul_valid  (mul_q_valid),
    .mul_tag    (mul_q_tag),
    .mul_data   (mul_q_data),
    .mul_flags  (mul_q_flags),
    .add_pop    (add_q_pop),
    .mul_pop    (mul_q_pop),
    .res_valid  (res_valid),
    .res_src    (res_src),
    .res_tag    (res_tag),
    .res_data   (res_data),
    .res_flags  (res_flags),
    .add_credit (p1_credit),
    .mul_credit (p2_credit)
  );

endmodule

/* fpu_cluster_asserts.sv */
module fpu_cluster_asserts import fpu_format_pkg::*, fpu_flow_pkg::*; (
  input logic              clk,
  input logic              rst,
  input logic              p1_valid,
  input add_op_e           p1_op,
  input logic [tag_w-1:0]  p1_tag,
  input logic [fp_w-1:0]   p1_a,
  input logic [fp_w-1:0]   p1_b,
  input fwd_sel_e          p1_sel_a,
  input fwd_sel_e          p1_sel_b,
  input logic              p2_valid,
  input mul_op_e           p2_op,
  input logic [tag_w-1:0]  p2_tag,
  input logic [fp_w-1:0]   p2_a,
  input logic [fp_w-1:0]   p2_b,
  input fwd_sel_e          p2_sel_a,
  input fwd_sel_e          p2_sel_b,
  input logic              p1_credit,
  input logic              p2_credit,
  input logic              res_valid,
  input logic [src_w-1:0]  res_src,
  input logic [tag_w-1:0]  res_tag,
  input logic [fp_w-1:0]   res_data,
  input logic [flag_w-1:0] res_flags
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // Expected {tag, data, flags} per port, index 0 is the add port
  logic [tag_w+fp_w+flag_w-1:0] exp_mem [2][8];
  logic [2:0]        wr_p [2];
  logic [2:0]        rd_p [2];
  logic [3:0]        cnt [2];
  logic [2:0]        probe;
  logic [fp_w-1:0]   bus_last;
  logic [tag_w-1:0]  head_tag;
  logic [fp_w-1:0]   head_data;
  logic [flag_w-1:0] head_flags;

  assign {head_tag, head_data, head_flags} = exp_mem[res_src][rd_p[res_src]];

  // ####################
  // Reference model

  // Value is mag * 2**scale, truncated toward zero into half precision
  function automatic logic [fp_w+flag_w-1:0] pack(logic sign, longint mag, int scale);
    int p;
    int be;
    longint frac;
    logic [flag_w-1:0] f;
    f = '0;
    p = 0;
    for (int i = 0; i < 63; i++) begin
      if (mag[i]) begin
        p = i;
      end
    end
    be = p + scale + exp_bias;
    if (be >= 31) begin
      f[flag_ovf] = 1'b1;
      f[flag_inx] = 1'b1;
      return {sign, 5'h1f, 10'h000, f};
    end
    if (be <= 0) begin
      f[flag_unf] = 1'b1;
      f[flag_inx] = 1'b1;
      return {sign, 15'h0000, f};
    end
    frac = mag >> (p - man_w);
    f[flag_inx] = (mag & ((longint'(1) << (p - man_w)) - longint'(1))) != 0;
    return {sign, be[4:0], frac[9:0], f};
  endfunction

  function automatic logic [fp_w+flag_w-1:0] add_model(add_op_e op, logic [15:0] a,
                                                         logic [15:0] b);
    logic [15:0] x;
    logic [15:0] y;
    logic sx;
    logic sy;
    longint mx;
    longint my;
    longint s;
    logic [flag_w-1:0] f;
    f = '0;
    case (op)
      add_op_and:  return {a & b, f};
      add_op_or:   return {a | b, f};
      add_op_xor:  return {a ^ b, f};
      add_op_andn: return {a & ~b, f};
      default: ;
    endcase
    x = (op == add_op_rsub) ? b : a;
    y = (op == add_op_rsub) ? a : b;
    if (x[14:10] == 5'h1f || y[14:10] == 5'h1f) begin
      f[flag_inv] = 1'b1;
      return {qnan_val, f};
    end
    sx = x[15];
    sy = y[15] ^ (op != add_op_add);
    // Exact operands in units of 2**-24, subnormals read as zero
    mx = (x[14:10] == 5'h00) ? 0 : longint'({1'b1, x[9:0]}) << (int'(x[14:10]) - 1);
    my = (y[14:10] == 5'h00) ? 0 : longint'({1'b1, y[9:0]}) << (int'(y[14:10]) - 1);
    s  = (sx ? -mx : mx) + (sy ? -my : my);
    if (s == 0) begin
      return {sx & sy, 15'h0000, f};
    end
    return pack(s < 0, (s < 0) ? -s : s, -24);
  endfunction

  function automatic logic [fp_w+flag_w-1:0] mul_model(mul_op_e op, logic [15:0] a,
                                                         logic [15:0] b);
    logic [15:0] c;
    logic sign;
    logic [flag_w-1:0] f;
    f = '0;
    c = (op == mul_op_sqr) ? a : b;
    sign = a[15] ^ c[15] ^ (op == mul_op_nmul);
    if (a[14:10] == 5'h1f || c[14:10] == 5'h1f) begin
      f[flag_inv] = 1'b1;
      return {qnan_val, f};
    end
    if (a[14:10] == 5'h00 || c[14:10] == 5'h00) begin
      return {sign, 15'h0000, f};
    end
    return pack(sign, longint'({1'b1, a[9:0]}) * longint'({1'b1, c[9:0]}),
                int'(a[14:10]) + int'(c[14:10]) - 2 * exp_bias - 2 * man_w);
  endfunction

  // Operand as the forwarding block sees it at this edge
  function automatic logic [fp_w-1:0] fwd_value(fwd_sel_e sel, logic [fp_w-1:0] value);
    case (sel)
      fwd_bus:      return res_data;
      fwd_bus_prev: return bus_last;
      default:      return value;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_p     <= '{default: '0};
      rd_p     <= '{default: '0};
      cnt      <= '{default: '0};
      probe    <= '0;
      bus_last <= '0;
    end else begin
      if (p1_valid) begin
        exp_mem[0][wr_p[0]] <= {p1_tag, add_model(p1_op, fwd_value(p1_sel_a, p1_a),
                                                  fwd_value(p1_sel_b, p1_b))};
        wr_p[0] <= wr_p[0] + 3'd1;
      end
      if (p2_valid) begin
        exp_mem[1][wr_p[1]] <= {p2_tag, mul_model(p2_op, fwd_value(p2_sel_a, p2_a),
                                                  fwd_value(p2_sel_b, p2_b))};
        wr_p[1] <= wr_p[1] + 3'd1;
      end
      if (res_valid) begin
        rd_p[res_src] <= rd_p[res_src] + 3'd1;
        bus_last      <= res_data;
      end
      cnt[0] <= cnt[0] + 4'(p1_valid) - 4'(res_valid && res_src == 1'b0);
      cnt[1] <= cnt[1] + 4'(p2_valid) - 4'(res_valid && res_src == 1'b1);
      // Lone issue with nothing in flight
      probe  <= {probe[1:0], (p1_valid ^ p2_valid) && cnt[0] == 4'd0 && cnt[1] == 4'd0};
    end
  end

  // ####################
  // Assertions

  a_tag: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> res_tag == head_tag)
    else begin
      $error("ERROR res_tag got %h expected %h", $sampled(res_tag), $sampled(head_tag));
      fail_count++;
    end

  a_data: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> res_data == head_data)
    else begin
      $error("ERROR res_data got %h expected %h", $sampled(res_data), $sampled(head_data));
      fail_count++;
    end

  a_flags: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> res_flags == head_flags)
    else begin
      $error("ERROR res_flags got %h expected %h", $sampled(res_flags),
             $sampled(head_flags));
      fail_count++;
    end

  a_credit: assert property (@(posedge clk) disable iff (rst)
    p1_credit == (res_valid && res_src == 1'b0) && p2_credit == (res_valid && res_src == 1'b1))
    else begin
      $error("Credit pulse does not match the port of the result on the bus");
      fail_count++;
    end

  a_outstanding: assert property (@(posedge clk) disable iff (rst)
    res_valid |-> cnt[res_src] != 4'd0)
    else begin
      $error("Result on the bus with no operation outstanding for that port");
      fail_count++;
    end

  a_credit_limit: assert property (@(posedge clk) disable iff (rst)
    int'(cnt[0]) <= port_credits && int'(cnt[1]) <= port_credits)
    else begin
      $error("More operations outstanding than the port has credits");
      fail_count++;
    end

  a_idle: assert property (@(posedge clk) disable iff (rst)
    (cnt[0] == 4'd0 && cnt[1] == 4'd0) |-> !res_valid && !p1_credit && !p2_credit)
    else begin
      $error("Result bus or credit active with no work outstanding");
      fail_count++;
    end

  // Uncontended result is valid exactly three cycles after issue
  a_latency: assert property (@(posedge clk) disable iff (rst)
    !(probe[1] && res_valid) && !(probe[2] && !res_valid))
    else begin
      $error("Uncontended result did not arrive three cycles after issue");
      fail_count++;
    end

endmodule

bind fpu_cluster fpu_cluster_asserts u_asserts (.*);

/* fpu_cluster_tb.sv */
module fpu_cluster_tb import fpu_format_pkg::*, fpu_flow_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_cycles    = 800;
  localparam int drain_timeout = 200;

  // Zero, +1.0, -1.0, 2.0, largest finite, smallest normal, infinity, NaN
  localparam logic [fp_w-1:0] specials [8] = '{16'h0000, 16'h3C00, 16'hBC00, 16'h4000,
                                                16'h7BFF, 16'h0400, 16'h7C00, 16'h7E00};

  logic              clk;
  logic              rst;
  logic              p1_valid;
  add_op_e           p1_op;
  logic [tag_w-1:0]  p1_tag;
  logic [fp_w-1:0]   p1_a;
  logic [fp_w-1:0]   p1_b;
  fwd_sel_e          p1_sel_a;
  fwd_sel_e          p1_sel_b;
  logic              p2_valid;
  mul_op_e           p2_op;
  logic [tag_w-1:0]  p2_tag;
  logic [fp_w-1:0]   p2_a;
  logic [fp_w-1:0]   p2_b;
  fwd_sel_e          p2_sel_a;
  fwd_sel_e          p2_sel_b;
  logic              p1_credit;
  logic              p2_credit;
  logic              res_valid;
  logic [src_w-1:0]  res_src;
  logic [tag_w-1:0]  res_tag;
  logic [fp_w-1:0]   res_data;
  logic [flag_w-1:0] res_flags;

  logic [31:0] seed;
  logic        seen_result;
  int          issued [2];
  int          returned [2];
  int          results;
  int          gap;

  fpu_cluster u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ####################
  // Helpers

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [fp_w-1:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[30:28] < 3'd3) begin
      return specials[r[26:24]];
    end
    return 16'(next_rand() >> 16);
  endfunction

  // Bus data is unknown until the first result
  function automatic fwd_sel_e pick_source();
    logic [31:0] r;
    r = next_rand();
    if (!seen_result || r[31:30] > 2'd1) begin
      return fwd_none;
    end
    return r[29] ? fwd_bus_prev : fwd_bus;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic sample_outputs();
    if (res_valid) begin
      results++;
      seen_result = 1'b1;
    end
    if (p1_credit) begin
      returned[0]++;
    end
    if (p2_credit) begin
      returned[1]++;
    end
    if (u_dut.u_asserts.fail_count != 0) begin
      stop_run("A checker assertion failed");
    end
  endtask

  task automatic drive_idle();
    p1_valid = 1'b0;
    p2_valid = 1'b0;
  endtask

  task automatic drive_issue();
    logic [31:0] r;
    r = next_rand();
    drive_idle();
    if (r[31] && issued[0] - returned[0] < port_credits) begin
      p1_valid = 1'b1;
      p1_op    = add_op_e'(3'((next_rand() >> 16) % 32'd7));
      p1_tag   = tag_w'(issued[0]);
      p1_a     = pick_operand();
      p1_b     = pick_operand();
      p1_sel_a = pick_source();
      p1_sel_b = pick_source();
      issued[0]++;
    end
    if (r[30] && issued[1] - returned[1] < port_credits) begin
      p2_valid = 1'b1;
      p2_op    = mul_op_e'(2'((next_rand() >> 16) % 32'd3));
      p2_tag   = tag_w'(issued[1]);
      p2_a     = pick_operand();
      p2_b     = pick_operand();
      p2_sel_a = pick_source();
      p2_sel_b = pick_source();
      issued[1]++;
    end
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      sample_outputs();
      drive_idle();
      cycles++;
      if (cycles > drain_timeout) begin
        stop_run("Timeout while waiting for outstanding results");
      end
    end while (issued[0] != returned[0] || issued[1] != returned[1]);
  endtask

  // ####################
  // Main sequence

  initial begin
    seed        = 32'ha7e5;
    seen_result = 1'b0;
    issued      = '{0, 0};
    returned    = '{0, 0};
    results     = 0;
    gap         = 0;
    rst         = 1'b1;
    p1_valid    = 1'b0;
    p1_op       = add_op_add;
    p1_tag      = '0;
    p1_a        = '0;
    p1_b        = '0;
    p1_sel_a    = fwd_none;
    p1_sel_b    = fwd_none;
    p2_valid    = 1'b0;
    p2_op       = mul_op_mul;
    p2_tag      = '0;
    p2_a        = '0;
    p2_b        = '0;
    p2_sel_a    = fwd_none;
    p2_sel_b    = fwd_none;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < num_cycles; i++) begin
      @(negedge clk);
      sample_outputs();
      if (gap > 0) begin
        gap--;
        drive_idle();
      end else if (next_rand() < 32'h1000_0000) begin
        // Idle stretch lets the pipeline drain for lone issues
        gap = int'(next_rand() >> 29) + 3;
        drive_idle();
      end else begin
        drive_issue();
      end
    end

    wait_for_drain();
    repeat (8) begin
      @(negedge clk);
      sample_outputs();
    end

    if (results != issued[0] + issued[1]) begin
      stop_run("Number of results does not match the number of issued operations");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

/* fpu_flow_pkg.sv */
package fpu_flow_pkg;

  // Instruction tag carried from issue to the result bus
  localparam int tag_w = 6;

  // Issue credits per port, queue sized to match so it cannot overflow
  localparam int port_credits = 4;
  localparam int queue_depth  = 4;

  // Result source id on the bus, 0 is the add unit, 1 the multiply unit
  localparam int src_w = 1;

  // Operand source select
  typedef enum logic [1:0] {
    fwd_none     = 2'd0,
    fwd_bus      = 2'd1,
    fwd_bus_prev = 2'd2
  } fwd_sel_e;

endpackage

/* fpu_format_pkg.sv */
package fpu_format_pkg;

  // Half precision word layout
  localparam int fp_w     = 16;
  localparam int exp_w    = 5;
  localparam int man_w    = 10;
  localparam int exp_bias = 15;

  // Canonical quiet NaN returned for any infinity or NaN input
  localparam logic [fp_w-1:0] qnan_val = 16'h7E00;

  // ####################
  // Exception flags

  localparam int flag_w   = 4;
  localparam int flag_inv = 0;
  localparam int flag_ovf = 1;
  localparam int flag_unf = 2;
  localparam int flag_inx = 3;

  // ####################
  // Opcodes

  // Port 1, add pipeline
  typedef enum logic [2:0] {
    add_op_add  = 3'd0,
    add_op_sub  = 3'd1,
    add_op_rsub = 3'd2,
    add_op_and  = 3'd3,
    add_op_or   = 3'd4,
    add_op_xor  = 3'd5,
    add_op_andn = 3'd6
  } add_op_e;

  // Port 2, multiply pipeline
  typedef enum logic [1:0] {
    mul_op_mul  = 2'd0,
    mul_op_nmul = 2'd1,
    mul_op_sqr  = 2'd2
  } mul_op_e;

endpackage

/* operand_fwd.sv */
module operand_fwd import fpu_format_pkg::*, fpu_flow_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  fwd_sel_e        sel,
  input  logic [fp_w-1:0] value,
  input  logic            bus_valid,
  input  logic [fp_w-1:0] bus_data,
  output logic [fp_w-1:0] operand
);

  logic [fp_w-1:0] bus_prev;

  // Last value that was actually driven on the result bus
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_prev <= '0;
    end else if (bus_valid) begin
      bus_prev <= bus_data;
    end
  end

  always_comb begin
    case (sel)
      fwd_bus:      operand = bus_data;
      fwd_bus_prev: operand = bus_prev;
      default:      operand = value;
    endcase
  end

endmodule

/* result_bus_arbiter.sv */
module result_bus_arbiter import fpu_format_pkg::*, fpu_flow_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              add_valid,
  input  logic [tag_w-1:0]  add_tag,
  input  logic [fp_w-1:0]   add_data,
  input  logic [flag_w-1:0] add_flags,
  input  logic              mul_valid,
  input  logic [tag_w-1:0]  mul_tag,
  input  logic [fp_w-1:0]   mul_data,
  input  logic [flag_w-1:0] mul_flags,
  output logic              add_pop,
  output logic              mul_pop,
  output logic              res_valid,
  output logic [src_w-1:0]  res_src,
  output logic [tag_w-1:0]  res_tag,
  output logic [fp_w-1:0]   res_data,
  output logic [flag_w-1:0] res_flags,
  output logic              add_credit,
  output logic              mul_credit
);

  logic prio_mul;
  logic grant_add, grant_mul;

  // Round robin, the unit not served last wins a tie
  assign grant_add = add_valid && (!mul_valid || !prio_mul);
  assign grant_mul = mul_valid && (!add_valid || prio_mul);
  assign add_pop   = grant_add;
  assign mul_pop   = grant_mul;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio_mul   <= 1'b0;
      res_valid  <= 1'b0;
      add_credit <= 1'b0;
      mul_credit <= 1'b0;
    end else begin
      if (grant_add || grant_mul) begin
        prio_mul <= grant_add;
      end
      res_valid  <= grant_add || grant_mul;
      add_credit <= grant_add;
      mul_credit <= grant_mul;
    end
  end

  // Bus payload holds its last value while idle
  always_ff @(posedge clk) begin
    if (grant_mul) begin
      res_src   <= src_w'(1);
      res_tag   <= mul_tag;
      res_data  <= mul_data;
      res_flags <= mul_flags;
    end else if (grant_add) begin
      res_src   <= '0;
      res_tag   <= add_tag;
      res_data  <= add_data;
      res_flags <= add_flags;
    end
  end

endmodule

/* result_queue.sv */
module result_queue import fpu_format_pkg::*, fpu_flow_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              push,
  input  logic [tag_w-1:0]  push_tag,
  input  logic [fp_w-1:0]   push_data,
  input  logic [flag_w-1:0] push_flags,
  input  logic              pop,
  output logic              valid,
  output logic [tag_w-1:0]  head_tag,
  output logic [fp_w-1:0]   head_data,
  output logic [flag_w-1:0] head_flags
);

  logic [tag_w-1:0]  tag_mem  [queue_depth];
  logic [fp_w-1:0]   data_mem [queue_depth];
  logic [flag_w-1:0] flag_mem [queue_depth];

  logic [$clog2(queue_depth)-1:0] wr_ptr;
  logic [$clog2(queue_depth)-1:0] rd_ptr;
  logic [$clog2(queue_depth):0]   count;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (!push && pop) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr]  <= push_tag;
      data_mem[wr_ptr] <= push_data;
      flag_mem[wr_ptr] <= push_flags;
    end
  end

  assign valid      = (count != '0);
  assign head_tag   = tag_mem[rd_ptr];
  assign head_data  = data_mem[rd_ptr];
  assign head_flags = flag_mem[rd_ptr];

endmodule
